//--- src/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] csr_word_t;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    typedef enum logic {
        RUNNING      = 1'b0,
        IN_EXCEPTION = 1'b1
    } trap_state_e;

    typedef struct packed {
        logic      we;
        csr_addr_e addr;
        csr_word_t wmask;
        csr_word_t wdata;
    } csr_wr_t;

    typedef struct packed {
        logic      ex_en;
        logic      ertn;
        ecode_e    ecode;
        logic      esubcode;
        csr_word_t pc;
    } exc_req_t;

    // estat split in two halves, merged in the read mux
    typedef struct packed {
        csr_word_t       crmd;
        csr_word_t       prmd;
        csr_word_t       ecfg;
        csr_word_t       estat_code;
        csr_word_t       estat_is;
        csr_word_t       era;
        csr_word_t       eentry;
        csr_word_t [3:0] save;
        csr_word_t       tid;
        csr_word_t       tcfg;
        csr_word_t       tval;
    } csr_view_t;

    localparam int CRMD_PLV_HI    = 1;
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_IE        = 2;
    localparam int PRMD_PPLV_HI   = 1;
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ESUB     = 22;
    localparam int IS_SW_HI       = 1;
    localparam int IS_SW_LO       = 0;
    localparam int IS_HW_HI       = 9;
    localparam int IS_HW_LO       = 2;
    localparam int IS_TIMER       = 11;
    localparam int INT_LINES      = 13;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TICLR_CLR      = 0;

    localparam csr_word_t CRMD_RESET     = 32'h0000_0008; // DA=1
    localparam csr_word_t CRMD_WMASK     = 32'h0000_01ff;
    localparam csr_word_t PRMD_WMASK     = 32'h0000_0007;
    localparam csr_word_t ECFG_WMASK     = 32'h0000_1bff;
    localparam csr_word_t ESTAT_SW_WMASK = 32'h0000_0003;
    localparam csr_word_t EENTRY_WMASK   = 32'hffff_ffc0;
    localparam csr_word_t FULL_WMASK     = 32'hffff_ffff;

    // new = wdata under mask, old elsewhere; only writable bits move
    function automatic csr_word_t masked_write(csr_word_t old, csr_word_t wdata,
                                               csr_word_t wmask, csr_word_t writable);
        csr_word_t m;
        m = wmask & writable;
        return (old & ~m) | (wdata & m);
    endfunction

    function automatic logic wr_hit(csr_wr_t wr, csr_addr_e addr);
        return wr.we && (wr.addr == addr);
    endfunction

endpackage

//--- src/csr_trap_regs.sv
module csr_trap_regs (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr,
    input  csr_pkg::exc_req_t  exc,
    output csr_pkg::csr_word_t crmd,
    output csr_pkg::csr_word_t prmd,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t eentry,
    output csr_pkg::csr_word_t estat_code,
    output logic               crmd_ie,
    output csr_pkg::csr_word_t new_pc
);

    csr_pkg::csr_word_t   crmd_q;
    csr_pkg::csr_word_t   prmd_q;
    csr_pkg::csr_word_t   era_q;
    csr_pkg::csr_word_t   eentry_q;
    csr_pkg::ecode_e      ecode_q;
    logic                 esub_q;
    csr_pkg::trap_state_e state_q;
    logic                 skip_insn;

    // entry beats ertn beats csr write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_q <= csr_pkg::CRMD_RESET;
        end else if (exc.ex_en) begin
            crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] <= 2'b00;
            crmd_q[csr_pkg::CRMD_IE] <= 1'b0;
        end else if (exc.ertn) begin
            crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] <=
                prmd_q[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
            crmd_q[csr_pkg::CRMD_IE] <= prmd_q[csr_pkg::PRMD_PIE];
        end else if (csr_pkg::wr_hit(wr, csr_pkg::CSR_CRMD)) begin
            crmd_q <= csr_pkg::masked_write(crmd_q, wr.wdata, wr.wmask, csr_pkg::CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_q <= '0;
        end else if (exc.ex_en) begin
            prmd_q[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO] <=
                crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
            prmd_q[csr_pkg::PRMD_PIE] <= crmd_q[csr_pkg::CRMD_IE];
        end else if (csr_pkg::wr_hit(wr, csr_pkg::CSR_PRMD)) begin
            prmd_q <= csr_pkg::masked_write(prmd_q, wr.wdata, wr.wmask, csr_pkg::PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_q    <= '0;
            eentry_q <= '0;
        end else begin
            if (exc.ex_en) begin
                era_q <= exc.pc;
            end else if (csr_pkg::wr_hit(wr, csr_pkg::CSR_ERA)) begin
                era_q <= csr_pkg::masked_write(era_q, wr.wdata, wr.wmask, csr_pkg::FULL_WMASK);
            end
            if (csr_pkg::wr_hit(wr, csr_pkg::CSR_EENTRY)) begin
                eentry_q <= csr_pkg::masked_write(eentry_q, wr.wdata, wr.wmask,
                                                  csr_pkg::EENTRY_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecode_q <= csr_pkg::ECODE_INT;
            esub_q  <= 1'b0;
            state_q <= csr_pkg::RUNNING;
        end else if (exc.ex_en) begin
            ecode_q <= exc.ecode;
            esub_q  <= exc.esubcode;
            state_q <= csr_pkg::IN_EXCEPTION;
        end else if (exc.ertn) begin
            state_q <= csr_pkg::RUNNING;
        end
    end

    // these codes resume past the faulting instruction
    assign skip_insn = (state_q == csr_pkg::IN_EXCEPTION) &&
                       (ecode_q inside {csr_pkg::ECODE_INT, csr_pkg::ECODE_SYS,
                                        csr_pkg::ECODE_BRK, csr_pkg::ECODE_INE});

    assign new_pc = skip_insn ? era_q + 32'd4 : era_q;

    always_comb begin
        estat_code = '0;
        estat_code[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO] = ecode_q;
        estat_code[csr_pkg::ESTAT_ESUB] = esub_q;
    end

    assign crmd    = crmd_q;
    assign prmd    = prmd_q;
    assign era     = era_q;
    assign eentry  = eentry_q;
    assign crmd_ie = crmd_q[csr_pkg::CRMD_IE];

    a_entry_ertn_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(exc.ex_en && exc.ertn));

endmodule

//--- src/csr_int_ctrl.sv
module csr_int_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr,
    input  logic [7:0]         hw_int,
    input  logic               timer_irq,
    input  logic               crmd_ie,
    output csr_pkg::csr_word_t ecfg,
    output csr_pkg::csr_word_t estat_is,
    output logic               has_int
);

    csr_pkg::csr_word_t ecfg_q;
    logic [1:0]         is_sw_q;
    logic [7:0]         is_hw_q;
    csr_pkg::csr_word_t sw_next;

    assign sw_next = csr_pkg::masked_write({30'b0, is_sw_q}, wr.wdata, wr.wmask,
                                           csr_pkg::ESTAT_SW_WMASK);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_q  <= '0;
            is_sw_q <= '0;
            is_hw_q <= '0;
        end else begin
            if (csr_pkg::wr_hit(wr, csr_pkg::CSR_ECFG)) begin
                ecfg_q <= csr_pkg::masked_write(ecfg_q, wr.wdata, wr.wmask, csr_pkg::ECFG_WMASK);
            end
            if (csr_pkg::wr_hit(wr, csr_pkg::CSR_ESTAT)) begin
                is_sw_q <= sw_next[csr_pkg::IS_SW_HI:csr_pkg::IS_SW_LO];
            end
            is_hw_q <= hw_int; // sampled every edge
        end
    end

    always_comb begin
        estat_is = '0;
        estat_is[csr_pkg::IS_SW_HI:csr_pkg::IS_SW_LO] = is_sw_q;
        estat_is[csr_pkg::IS_HW_HI:csr_pkg::IS_HW_LO] = is_hw_q;
        estat_is[csr_pkg::IS_TIMER] = timer_irq;
    end

    assign has_int = crmd_ie &&
                     |(ecfg_q[csr_pkg::INT_LINES-1:0] & estat_is[csr_pkg::INT_LINES-1:0]);
    assign ecfg    = ecfg_q;

endmodule

//--- src/csr_timer.sv
module csr_timer #(
    parameter int unsigned TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               timer_irq
);

    csr_pkg::csr_word_t tcfg_q;
    csr_pkg::csr_word_t tcfg_next;
    logic [TIMER_W-1:0] tval_q;
    logic [TIMER_W-1:0] load_val;
    logic [TIMER_W-1:0] reload_val;
    logic               timer_en;
    logic               tcfg_hit;
    logic               ticlr_hit;
    logic               expire;

    assign tcfg_hit  = csr_pkg::wr_hit(wr, csr_pkg::CSR_TCFG);
    assign ticlr_hit = csr_pkg::wr_hit(wr, csr_pkg::CSR_TICLR);
    assign tcfg_next = csr_pkg::masked_write(tcfg_q, wr.wdata, wr.wmask, csr_pkg::FULL_WMASK);

    // initval lives in 31:2, counter counts in units of 1
    assign load_val   = TIMER_W'({tcfg_next[31:2], 2'b00});
    assign reload_val = TIMER_W'({tcfg_q[31:2], 2'b00});
    assign expire     = timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_q   <= '0;
            tval_q   <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_hit) begin
            tcfg_q   <= tcfg_next;
            tval_q   <= load_val;
            timer_en <= tcfg_next[csr_pkg::TCFG_EN];
        end else if (timer_en) begin
            if (!expire) begin
                tval_q <= tval_q - 1'b1;
            end else if (tcfg_q[csr_pkg::TCFG_PERIODIC]) begin
                tval_q <= reload_val;
            end else begin
                tval_q   <= '1; // one-shot parks at all ones
                timer_en <= 1'b0;
            end
        end
    end

    // clear wins over a same-cycle expiry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_irq <= 1'b0;
        end else if (ticlr_hit && wr.wdata[csr_pkg::TICLR_CLR]) begin
            timer_irq <= 1'b0;
        end else if (expire && !tcfg_hit) begin
            timer_irq <= 1'b1;
        end
    end

    assign tcfg = tcfg_q;
    assign tval = 32'(tval_q);

    a_periodic_no_wrap: assert property (@(posedge clk) disable iff (!rstn)
        (expire && !tcfg_hit && tcfg_q[csr_pkg::TCFG_PERIODIC]) |=> (tval_q != '1));

endmodule

//--- src/csr_scratch_regs.sv
module csr_scratch_regs (
    input  logic                     clk,
    input  logic                     rstn,
    input  csr_pkg::csr_wr_t         wr,
    output csr_pkg::csr_word_t [3:0] save,
    output csr_pkg::csr_word_t       tid
);

    csr_pkg::csr_word_t [3:0] save_q;
    csr_pkg::csr_word_t       tid_q;

    for (genvar i = 0; i < 4; i++) begin : g_save
        localparam csr_pkg::csr_addr_e ADDR = csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + i);

        always_ff @(posedge clk) begin
            if (!rstn) begin
                save_q[i] <= '0;
            end else if (csr_pkg::wr_hit(wr, ADDR)) begin
                save_q[i] <= csr_pkg::masked_write(save_q[i], wr.wdata, wr.wmask,
                                                   csr_pkg::FULL_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tid_q <= '0;
        end else if (csr_pkg::wr_hit(wr, csr_pkg::CSR_TID)) begin
            tid_q <= csr_pkg::masked_write(tid_q, wr.wdata, wr.wmask, csr_pkg::FULL_WMASK);
        end
    end

    assign save = save_q;
    assign tid  = tid_q;

endmodule

//--- src/csr_read_port.sv
module csr_read_port (
    input  csr_pkg::csr_addr_e raddr,
    input  csr_pkg::csr_view_t view,
    output csr_pkg::csr_word_t rdata
);

    always_comb begin
        case (raddr)
            csr_pkg::CSR_CRMD: begin
                rdata = view.crmd;
            end
            csr_pkg::CSR_PRMD: begin
                rdata = view.prmd;
            end
            csr_pkg::CSR_ECFG: begin
                rdata = view.ecfg;
            end
            csr_pkg::CSR_ESTAT: begin
                rdata = view.estat_code | view.estat_is; // halves never overlap
            end
            csr_pkg::CSR_ERA: begin
                rdata = view.era;
            end
            csr_pkg::CSR_EENTRY: begin
                rdata = view.eentry;
            end
            csr_pkg::CSR_SAVE0: begin
                rdata = view.save[0];
            end
            csr_pkg::CSR_SAVE1: begin
                rdata = view.save[1];
            end
            csr_pkg::CSR_SAVE2: begin
                rdata = view.save[2];
            end
            csr_pkg::CSR_SAVE3: begin
                rdata = view.save[3];
            end
            csr_pkg::CSR_TID: begin
                rdata = view.tid;
            end
            csr_pkg::CSR_TCFG: begin
                rdata = view.tcfg;
            end
            csr_pkg::CSR_TVAL: begin
                rdata = view.tval;
            end
            default: begin
                rdata = '0; // ticlr and holes
            end
        endcase
    end

endmodule

//--- src/csr_top.sv
module csr_top #(
    parameter int unsigned TIMER_W = 32
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::csr_wr_t     wr,
    input  csr_pkg::csr_addr_e   raddr,
    input  csr_pkg::csr_addr_e   raddr_fwd,
    input  csr_pkg::exc_req_t    exc,
    input  logic [7:0]           hw_int,
    output csr_pkg::csr_word_t   rdata,
    output csr_pkg::csr_word_t   rdata_fwd,
    output csr_pkg::csr_word_t   new_pc,
    output csr_pkg::csr_word_t   ex_entry_pc,
    output logic                 has_int
);

    csr_pkg::csr_word_t       crmd;
    csr_pkg::csr_word_t       prmd;
    csr_pkg::csr_word_t       era;
    csr_pkg::csr_word_t       eentry;
    csr_pkg::csr_word_t       estat_code;
    csr_pkg::csr_word_t       ecfg;
    csr_pkg::csr_word_t       estat_is;
    csr_pkg::csr_word_t       tcfg;
    csr_pkg::csr_word_t       tval;
    csr_pkg::csr_word_t [3:0] save;
    csr_pkg::csr_word_t       tid;
    logic                     crmd_ie;
    logic                     timer_irq;
    csr_pkg::csr_view_t       view;

    csr_trap_regs trap_i (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .exc        (exc),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era),
        .eentry     (eentry),
        .estat_code (estat_code),
        .crmd_ie    (crmd_ie),
        .new_pc     (new_pc)
    );

    csr_int_ctrl int_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .hw_int    (hw_int),
        .timer_irq (timer_irq),
        .crmd_ie   (crmd_ie),
        .ecfg      (ecfg),
        .estat_is  (estat_is),
        .has_int   (has_int)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) timer_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_irq (timer_irq)
    );

    csr_scratch_regs scratch_i (
        .clk  (clk),
        .rstn (rstn),
        .wr   (wr),
        .save (save),
        .tid  (tid)
    );

    assign view = '{
        crmd:       crmd,
        prmd:       prmd,
        ecfg:       ecfg,
        estat_code: estat_code,
        estat_is:   estat_is,
        era:        era,
        eentry:     eentry,
        save:       save,
        tid:        tid,
        tcfg:       tcfg,
        tval:       tval
    };

    assign ex_entry_pc = eentry;

    csr_read_port rd_main_i (
        .raddr (raddr),
        .view  (view),
        .rdata (rdata)
    );

    csr_read_port rd_fwd_i (
        .raddr (raddr_fwd),
        .view  (view),
        .rdata (rdata_fwd)
    );

endmodule

//--- bench/csr_tb_table.svh
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

typedef enum logic [2:0] {
    WRITE,
    READ,
    EXC,
    ERTN,
    HWINT,
    IDLE
} kind_e;

typedef struct packed {
    kind_e              kind;
    logic [13:0]        addr;
    csr_pkg::csr_word_t mask;
    csr_pkg::csr_word_t data;          // hw lines for HWINT
    csr_pkg::ecode_e    ecode;
    csr_pkg::csr_word_t pc;
    int                 hold;
    csr_pkg::csr_word_t exp_rdata;
    csr_pkg::csr_word_t exp_rdata_fwd;
    csr_pkg::csr_word_t exp_new_pc;
    csr_pkg::csr_word_t exp_entry_pc;
    logic               exp_has_int;
} entry_t;

entry_t table_q[$];

function automatic csr_pkg::csr_word_t writable_bits(logic [13:0] addr);
    case (addr)
        csr_pkg::CSR_CRMD:   return 32'h0000_01ff;
        csr_pkg::CSR_PRMD:   return 32'h0000_0007;
        csr_pkg::CSR_ECFG:   return 32'h0000_1bff; // lines 9:0 and 12:11
        csr_pkg::CSR_ESTAT:  return 32'h0000_0003; // software lines only
        csr_pkg::CSR_EENTRY: return 32'hffff_ffc0;
        csr_pkg::CSR_ERA, csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
        csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG: return 32'hffff_ffff;
        default:             return 32'h0000_0000;
    endcase
endfunction

function automatic csr_pkg::csr_word_t expected_new_pc();
    logic skip;
    skip = in_exc && (last_code inside {csr_pkg::ECODE_INT, csr_pkg::ECODE_SYS,
                                        csr_pkg::ECODE_BRK, csr_pkg::ECODE_INE});
    return skip ? model[csr_pkg::CSR_ERA] + 32'd4 : model[csr_pkg::CSR_ERA];
endfunction

function automatic logic pending_int();
    return model[csr_pkg::CSR_CRMD][2] &&
           (|(model[csr_pkg::CSR_ECFG][12:0] & model[csr_pkg::CSR_ESTAT][12:0]));
endfunction

// expected outputs are taken from the model as it stands after the step
function automatic void append_entry(kind_e kind, logic [13:0] addr, csr_pkg::csr_word_t mask,
                                     csr_pkg::csr_word_t data, csr_pkg::ecode_e ecode,
                                     int hold, csr_pkg::csr_word_t exp);
    entry_t e;
    e.kind          = kind;
    e.addr          = addr;
    e.mask          = mask;
    e.data          = data;
    e.ecode         = ecode;
    e.pc            = (kind == EXC) ? data : 32'h0;
    e.hold          = hold;
    e.exp_rdata     = exp;
    e.exp_rdata_fwd = exp;
    e.exp_new_pc    = expected_new_pc();
    e.exp_entry_pc  = model[csr_pkg::CSR_EENTRY];
    e.exp_has_int   = pending_int();
    table_q.push_back(e);
endfunction

function automatic void write_csr(logic [13:0] addr, csr_pkg::csr_word_t mask,
                                  csr_pkg::csr_word_t data);
    csr_pkg::csr_word_t m;
    m = mask & writable_bits(addr);
    model[addr] = (model[addr] & ~m) | (data & m);
    if (addr == csr_pkg::CSR_TCFG) begin
        model[csr_pkg::CSR_TVAL] = model[csr_pkg::CSR_TCFG] & 32'hffff_fffc;
    end
    if (addr == csr_pkg::CSR_TICLR && data[0]) begin
        model[csr_pkg::CSR_ESTAT][11] = 1'b0;
    end
    append_entry(WRITE, addr, mask, data, csr_pkg::ECODE_INT, 0, 32'h0);
endfunction

function automatic void read_csr(logic [13:0] addr, int hold, csr_pkg::csr_word_t exp);
    append_entry(READ, addr, 32'h0, 32'h0, csr_pkg::ECODE_INT, hold, exp);
endfunction

function automatic void read_back(logic [13:0] addr);
    read_csr(addr, 0, model[addr]);
endfunction

function automatic void raise_exc(csr_pkg::ecode_e ecode, csr_pkg::csr_word_t pc);
    model[csr_pkg::CSR_PRMD][2:0]    = model[csr_pkg::CSR_CRMD][2:0];
    model[csr_pkg::CSR_CRMD][2:0]    = 3'b000;
    model[csr_pkg::CSR_ERA]          = pc;
    model[csr_pkg::CSR_ESTAT][21:16] = ecode;
    model[csr_pkg::CSR_ESTAT][22]    = 1'b0;
    in_exc    = 1'b1;
    last_code = ecode;
    append_entry(EXC, 14'h0, 32'h0, pc, ecode, 0, 32'h0);
endfunction

function automatic void return_exc();
    model[csr_pkg::CSR_CRMD][2:0] = model[csr_pkg::CSR_PRMD][2:0];
    in_exc = 1'b0;
    append_entry(ERTN, 14'h0, 32'h0, 32'h0, csr_pkg::ECODE_INT, 0, 32'h0);
endfunction

function automatic void set_hw_lines(logic [7:0] lines);
    model[csr_pkg::CSR_ESTAT][9:2] = lines;
    append_entry(HWINT, 14'h0, 32'h0, {24'h0, lines}, csr_pkg::ECODE_INT, 0, 32'h0);
endfunction

task automatic build_table();
    csr_pkg::csr_addr_e regs [12];
    csr_pkg::csr_word_t data;
    csr_pkg::csr_word_t mask;
    csr_pkg::csr_word_t pc;
    regs = '{csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
             csr_pkg::CSR_ERA, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
             csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG};
    model = '{default: 32'h0};
    model[csr_pkg::CSR_CRMD] = 32'h0000_0008;
    in_exc    = 1'b0;
    last_code = csr_pkg::ECODE_INT;

    // reset values
    foreach (regs[i]) read_back(regs[i]);
    read_back(csr_pkg::CSR_TVAL);
    read_back(csr_pkg::CSR_TICLR);

    // random data under random masks
    foreach (regs[i]) begin
        data = $urandom();
        mask = $urandom();
        if (regs[i] == csr_pkg::CSR_TCFG) begin
            data[0] = 1'b0; // timer stays stopped
        end
        write_csr(regs[i], mask, data);
        read_back(regs[i]);
    end
    read_back(csr_pkg::CSR_TVAL);
    write_csr(csr_pkg::CSR_TICLR, 32'hffff_ffff, 32'hffff_ffff);
    read_back(csr_pkg::CSR_TICLR);
    read_csr(14'h002, 0, 32'h0); // hole in the map

    write_csr(csr_pkg::CSR_ECFG, 32'hffff_ffff, 32'h0);
    write_csr(csr_pkg::CSR_ESTAT, 32'hffff_ffff, 32'h0);
    write_csr(csr_pkg::CSR_CRMD, 32'hffff_ffff, 32'h0000_0008);

    // exception entry and return
    pc = 32'h1c00_0100;
    write_csr(csr_pkg::CSR_CRMD, 32'h7, 32'h7); // plv 3, ie
    raise_exc(csr_pkg::ECODE_SYS, pc);
    read_back(csr_pkg::CSR_PRMD);
    read_back(csr_pkg::CSR_CRMD);
    read_back(csr_pkg::CSR_ERA);
    read_back(csr_pkg::CSR_ESTAT);
    return_exc();
    read_back(csr_pkg::CSR_CRMD);
    raise_exc(csr_pkg::ECODE_ALE, pc + 32'h40);
    read_back(csr_pkg::CSR_ESTAT);
    return_exc();
    read_back(csr_pkg::CSR_CRMD);

    // hw line 1 lands on is bit 3
    write_csr(csr_pkg::CSR_ECFG, 32'hffff_ffff, 32'h8);
    set_hw_lines(8'h02);
    read_back(csr_pkg::CSR_ESTAT);
    write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
    write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
    write_csr(csr_pkg::CSR_ECFG, 32'h8, 32'h0);
    set_hw_lines(8'h00);
    write_csr(csr_pkg::CSR_ECFG, 32'h1, 32'h1);
    write_csr(csr_pkg::CSR_ESTAT, 32'h1, 32'h1);
    read_back(csr_pkg::CSR_ESTAT);
    write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
    write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
    write_csr(csr_pkg::CSR_ECFG, 32'h1, 32'h0);
    write_csr(csr_pkg::CSR_ESTAT, 32'h1, 32'h0);
    append_entry(IDLE, 14'h0, 32'h0, 32'h0, csr_pkg::ECODE_INT, 2, 32'h0);

    // one-shot with initval 2 counted from the write edge as edge 0
    write_csr(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'h9);
    read_csr(csr_pkg::CSR_ESTAT, 7, model[csr_pkg::CSR_ESTAT]); // edge 8
    model[csr_pkg::CSR_ESTAT][11] = 1'b1;
    read_back(csr_pkg::CSR_ESTAT);                                // edge 9
    model[csr_pkg::CSR_TVAL] = 32'hffff_ffff;
    read_back(csr_pkg::CSR_TVAL);
    read_back(csr_pkg::CSR_TCFG);
    write_csr(csr_pkg::CSR_TICLR, 32'hffff_ffff, 32'h1);
    read_back(csr_pkg::CSR_ESTAT);

    // periodic reload
    write_csr(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'hb);
    read_csr(csr_pkg::CSR_ESTAT, 7, model[csr_pkg::CSR_ESTAT]);
    read_csr(csr_pkg::CSR_TVAL, 0, 32'h8);                        // edge 9
    model[csr_pkg::CSR_ESTAT][11] = 1'b1;
    read_back(csr_pkg::CSR_ESTAT);
    write_csr(csr_pkg::CSR_TICLR, 32'hffff_ffff, 32'h1);         // edge 11
    read_csr(csr_pkg::CSR_ESTAT, 5, model[csr_pkg::CSR_ESTAT]);  // edge 17
    model[csr_pkg::CSR_ESTAT][11] = 1'b1;
    read_back(csr_pkg::CSR_ESTAT);                                // second expiry
    write_csr(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'h0);
    read_back(csr_pkg::CSR_TVAL);
    write_csr(csr_pkg::CSR_TICLR, 32'hffff_ffff, 32'h1);
    read_back(csr_pkg::CSR_ESTAT);
endtask

`endif

//--- bench/csr_tb.sv
module csr_tb;

    logic               clk = 1'b0;
    logic               rstn;
    csr_pkg::csr_wr_t   wr;
    csr_pkg::csr_addr_e raddr;
    csr_pkg::csr_addr_e raddr_fwd;
    csr_pkg::exc_req_t  exc;
    logic [7:0]         hw_int;
    csr_pkg::csr_word_t rdata;
    csr_pkg::csr_word_t rdata_fwd;
    csr_pkg::csr_word_t new_pc;
    csr_pkg::csr_word_t ex_entry_pc;
    logic               has_int;

    bit                 table_built;
    int                 cur_idx;
    csr_pkg::csr_word_t model [0:16383]; // expected contents by csr address
    logic               in_exc;
    csr_pkg::ecode_e    last_code;

    `include "csr_tb_table.svh"

    csr_top #(
        .TIMER_W (32)
    ) csr_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .wr          (wr),
        .raddr       (raddr),
        .raddr_fwd   (raddr_fwd),
        .exc         (exc),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .rdata_fwd   (rdata_fwd),
        .new_pc      (new_pc),
        .ex_entry_pc (ex_entry_pc),
        .has_int     (has_int)
    );

    always #50 clk = ~clk;

    task automatic check_word(string what, csr_pkg::csr_word_t got, csr_pkg::csr_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s at entry %0d: got %h, expected %h",
                     $time, what, cur_idx, got, exp);
            $display("Finished with errors");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s at entry %0d: got %b, expected %b",
                     $time, what, cur_idx, got, exp);
            $display("Finished with errors");
            $fatal(1, "flag mismatch");
        end
    endtask

    // called on a falling edge, returns on the falling edge where results are checked
    task automatic apply_entry(entry_t e);
        case (e.kind)
            WRITE: begin
                wr.we    = 1'b1;
                wr.addr  = csr_pkg::csr_addr_e'(e.addr);
                wr.wmask = e.mask;
                wr.wdata = e.data;
            end
            READ: begin
                raddr     = csr_pkg::csr_addr_e'(e.addr);
                raddr_fwd = csr_pkg::csr_addr_e'(e.addr);
            end
            EXC: begin
                exc.ex_en = 1'b1;
                exc.ecode = e.ecode;
                exc.pc    = e.pc;
            end
            ERTN:    exc.ertn = 1'b1;
            HWINT:   hw_int = e.data[7:0];
            default: ;
        endcase
        @(negedge clk);
        wr.we     = 1'b0; // single-cycle pulses
        exc.ex_en = 1'b0;
        exc.ertn  = 1'b0;
        repeat (e.hold) @(negedge clk);
    endtask

    task automatic check_entry(entry_t e);
        if (e.kind == READ) begin
            check_word("rdata", rdata, e.exp_rdata);
            check_word("rdata_fwd", rdata_fwd, e.exp_rdata_fwd);
        end
        check_word("new_pc", new_pc, e.exp_new_pc);
        check_word("ex_entry_pc", ex_entry_pc, e.exp_entry_pc);
        check_flag("has_int", has_int, e.exp_has_int);
    endtask

    initial begin
        int unsigned budget;
        wait (table_built);
        budget = 0;
        foreach (table_q[i]) budget += table_q[i].hold + 10;
        #(budget * 100);
        $display("simulation timed out after %0d cycles", budget);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int unsigned seed_sink;
        seed_sink = $urandom(71757);
        rstn      = 1'b0;
        wr        = '0;
        exc       = '0;
        raddr     = csr_pkg::CSR_CRMD;
        raddr_fwd = csr_pkg::CSR_CRMD;
        hw_int    = 8'h00;
        build_table();
        table_built = 1'b1;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        foreach (table_q[i]) begin
            cur_idx = i;
            apply_entry(table_q[i]);
            check_entry(table_q[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+bench
src/csr_pkg.sv
src/csr_trap_regs.sv
src/csr_int_ctrl.sv
src/csr_timer.sv
src/csr_scratch_regs.sv
src/csr_read_port.sv
src/csr_top.sv
bench/csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the csr testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f verilog.f -o csr_sim \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
